// File: tcdm_macros.svh
`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

// --------------------
// channel counts
// --------------------

`define TCDM_NB_IN  4  // virtual core channels seen by the accelerator.
`define TCDM_NB_OUT 2  // physical ports into the shared memory.

// --------------------
// widths and depth
// --------------------

`define TCDM_DW  32  // data word width in bits.
`define TCDM_AW  8   // word address width, so no byte offset here.
`define TCDM_UW  4   // user tag width, echoed back with every response.

`define TCDM_BEW (`TCDM_DW / 8)  // one byte enable per data byte.

`define TCDM_MEM_WORDS 256  // number of words in the shared memory.

`endif

// File: tcdm_pkg.sv
`include "tcdm_macros.svh"

package tcdm_pkg;

  // --------------------
  // channel bundles
  // --------------------

  // request side of one channel, driven by the master.
  typedef struct packed {
    logic                  req;   // request strobe, held until granted.
    logic [`TCDM_AW-1:0]   add;   // word address.
    logic                  wen;   // high for a read, low for a write.
    logic [`TCDM_BEW-1:0]  be;    // byte enables, only looked at on writes.
    logic [`TCDM_DW-1:0]   data;  // write data.
    logic [`TCDM_UW-1:0]   user;  // tag that comes back on the response.
  } tcdm_req_t;

  // response side of one channel, driven by the slave.
  typedef struct packed {
    logic                  r_valid;  // one cycle after every accepted request.
    logic [`TCDM_DW-1:0]   r_data;   // read data, meaningless after a write.
    logic [`TCDM_UW-1:0]   r_user;   // copy of the request tag.
  } tcdm_rsp_t;

  // --------------------
  // storage
  // --------------------

  // one memory word. Reads take the whole word, writes go byte by byte.
  typedef union packed {
    logic [`TCDM_DW-1:0]        word;   // full word view.
    logic [`TCDM_BEW-1:0][7:0]  bytes;  // bytes[0] is word[7:0].
  } tcdm_word_t;

endpackage

// File: tcdm_mux_dynamic.sv
`timescale 1ns/1ps

`include "tcdm_macros.svh"

module tcdm_mux_dynamic #(
  parameter int unsigned NB_IN_CHAN  = `TCDM_NB_IN,   // virtual channels on the core side.
  parameter int unsigned NB_OUT_CHAN = `TCDM_NB_OUT   // ports on the memory side.
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  tcdm_pkg::tcdm_req_t [NB_IN_CHAN-1:0]  in_req,
  output logic                [NB_IN_CHAN-1:0]  in_gnt,
  output tcdm_pkg::tcdm_rsp_t [NB_IN_CHAN-1:0]  in_rsp,
  output tcdm_pkg::tcdm_req_t [NB_OUT_CHAN-1:0] out_req,
  input  logic                [NB_OUT_CHAN-1:0] out_gnt,
  input  tcdm_pkg::tcdm_rsp_t [NB_OUT_CHAN-1:0] out_rsp
);

  localparam int unsigned G  = NB_IN_CHAN / NB_OUT_CHAN;  // channels sharing one port.
  localparam int unsigned GW = (G > 1) ? $clog2(G) : 1;   // width of a member index.

  logic [GW-1:0]                  rr_counter;  // shared rotation offset, 0 to G-1.
  logic                           rr_en;       // advance the rotation this cycle.
  logic [NB_OUT_CHAN-1:0][G-1:0]  grp_req;     // request bits, regrouped per port.
  logic [NB_OUT_CHAN-1:0][G-1:0]  grp_gnt;     // grant bits, regrouped per port.
  logic [NB_OUT_CHAN-1:0][GW-1:0] winner_d;    // member that owns the port now.
  logic [NB_OUT_CHAN-1:0][GW-1:0] winner_q;    // member that owned it last cycle.
  logic [NB_OUT_CHAN-1:0]         out_acc;     // port request accepted this cycle.
  logic [NB_OUT_CHAN-1:0]         out_req_q;   // port request accepted last cycle.

  // member k of port p is input channel k*NB_OUT_CHAN+p.
  always_comb begin : group_gather
    for (int p = 0; p < NB_OUT_CHAN; p++) begin
      for (int k = 0; k < G; k++) begin
        grp_req[p][k] = in_req[k*NB_OUT_CHAN+p].req;  // who wants this port.
        grp_gnt[p][k] = in_gnt[k*NB_OUT_CHAN+p];      // who got it.
      end
    end
  end

  // --------------------
  // round robin counter
  // --------------------

  assign rr_en = (|grp_req) & (|out_gnt);  // some port did work, so rotate.

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter_reg
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear_i) begin
      rr_counter <= '0;  // restart the rotation from member 0.
    end else if (rr_en) begin
      if (rr_counter == GW'(G - 1)) begin
        rr_counter <= '0;  // wrap at the group size.
      end else begin
        rr_counter <= rr_counter + 1'b1;
      end
    end
  end

  // --------------------
  // winner selection
  // --------------------

  // scan from rr_counter+p upwards. The last requester in the scan wins, so the
  // member right at the offset has the lowest priority this cycle.
  always_comb begin : winner_select
    int unsigned idx;
    idx = 0;
    for (int p = 0; p < NB_OUT_CHAN; p++) begin
      winner_d[p] = GW'((32'(rr_counter) + 32'(p)) % G);  // fallback when idle.
      for (int k = 0; k < G; k++) begin
        idx = (32'(rr_counter) + 32'(p) + 32'(k)) % G;  // rotated member index.
        if (grp_req[p][idx]) begin
          winner_d[p] = GW'(idx);  // later hits override earlier ones.
        end
      end
    end
  end

  // the winner's bundle goes straight to the port. An idle winner carries req low.
  always_comb begin : req_mux
    for (int p = 0; p < NB_OUT_CHAN; p++) begin
      out_req[p] = in_req[32'(winner_d[p])*NB_OUT_CHAN+p];  // zero-cycle path.
      out_acc[p] = out_req[p].req & out_gnt[p];             // handshake on the port.
    end
  end

  // --------------------
  // grant and response
  // --------------------

  // grant follows the current winner. The response follows last cycle's winner.
  always_comb begin : gnt_rsp_route
    in_gnt = '0;
    in_rsp = '0;  // losers and idle channels see an all-zero response.
    for (int p = 0; p < NB_OUT_CHAN; p++) begin
      in_gnt[32'(winner_d[p])*NB_OUT_CHAN+p] = out_acc[p];
      in_rsp[32'(winner_q[p])*NB_OUT_CHAN+p] = out_rsp[p];  // data and tag.
      in_rsp[32'(winner_q[p])*NB_OUT_CHAN+p].r_valid =
        out_rsp[p].r_valid & out_req_q[p];  // only if something was accepted.
    end
  end

  // remember who was served, so the response one cycle later is steered right.
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
    if (!rst_ni) begin
      winner_q  <= '0;
      out_req_q <= '0;
    end else begin
      winner_q  <= winner_d;
      out_req_q <= out_acc;
    end
  end

  // --------------------
  // assertions
  // --------------------

  a_group_even: assert property (@(posedge clk_i) (NB_IN_CHAN % NB_OUT_CHAN) == 0)
    else $error("input channels do not split evenly over the ports.");

  for (genvar p = 0; p < NB_OUT_CHAN; p++) begin : g_port_chk
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(grp_gnt[p]))
      else $error("more than one grant in group %0d.", p);
  end

  for (genvar j = 0; j < NB_IN_CHAN; j++) begin : g_chan_chk
    // a response on a channel must belong to a grant one cycle earlier.
    a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_rsp[j].r_valid |-> $past(in_gnt[j]))
      else $error("response on channel %0d without a grant.", j);
  end

endmodule

// File: tcdm_multiport_mem.sv
`timescale 1ns/1ps

`include "tcdm_macros.svh"

module tcdm_multiport_mem #(
  parameter int unsigned NB_PORTS = `TCDM_NB_OUT  // independent access ports.
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  tcdm_pkg::tcdm_req_t [NB_PORTS-1:0] port_req,
  output logic                [NB_PORTS-1:0] port_gnt,
  output tcdm_pkg::tcdm_rsp_t [NB_PORTS-1:0] port_rsp
);

  import tcdm_pkg::*;

  tcdm_word_t                        mem_q [`TCDM_MEM_WORDS];  // the shared storage.
  logic [NB_PORTS-1:0]               acc;        // port handshake done this cycle.
  logic [NB_PORTS-1:0]               r_valid_q;  // response strobe, one per port.
  logic [NB_PORTS-1:0][`TCDM_UW-1:0] r_user_q;   // tag to echo back.
  logic [NB_PORTS-1:0][`TCDM_DW-1:0] r_data_q;   // word read on the previous cycle.

  // no bank conflicts here, every port that asks is served at once.
  always_comb begin : grant_all
    for (int p = 0; p < NB_PORTS; p++) begin
      port_gnt[p] = port_req[p].req;
      acc[p]      = port_req[p].req & port_gnt[p];
    end
  end

  // --------------------
  // write path
  // --------------------

  // ports are visited from the top down. The last assignment to a byte sticks,
  // so port 0 beats port 1 on every byte both of them enable.
  always_ff @(posedge clk_i) begin : mem_write
    for (int p = NB_PORTS - 1; p >= 0; p--) begin
      if (acc[p] && !port_req[p].wen) begin
        for (int b = 0; b < `TCDM_BEW; b++) begin
          if (port_req[p].be[b]) begin
            mem_q[port_req[p].add].bytes[b] <= port_req[p].data[8*b +: 8];  // byte lane b.
          end
        end
      end
    end
  end

  // --------------------
  // read path
  // --------------------

  // reads sample the array before this edge's writes land, so a same-cycle
  // write to the address is not visible until the next access.
  always_ff @(posedge clk_i) begin : read_payload
    for (int p = 0; p < NB_PORTS; p++) begin
      if (acc[p]) begin
        r_user_q[p] <= port_req[p].user;  // writes echo their tag too.
        if (port_req[p].wen) begin
          r_data_q[p] <= mem_q[port_req[p].add].word;  // whole word view.
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : read_valid
    if (!rst_ni) begin
      r_valid_q <= '0;
    end else begin
      r_valid_q <= acc;  // exactly one cycle behind acceptance, never stalled.
    end
  end

  always_comb begin : rsp_drive
    for (int p = 0; p < NB_PORTS; p++) begin
      port_rsp[p].r_valid = r_valid_q[p];
      port_rsp[p].r_data  = r_data_q[p];
      port_rsp[p].r_user  = r_user_q[p];
    end
  end

  // --------------------
  // assertions
  // --------------------

  for (genvar p = 0; p < NB_PORTS; p++) begin : g_port_chk
    a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      port_rsp[p].r_valid == $past(port_req[p].req & port_gnt[p]))
      else $error("port %0d response is not one cycle after its request.", p);
  end

endmodule

// File: tcdm_subsystem.sv
`timescale 1ns/1ps

`include "tcdm_macros.svh"

module tcdm_subsystem (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  tcdm_pkg::tcdm_req_t [`TCDM_NB_IN-1:0] core_req,
  output logic                [`TCDM_NB_IN-1:0] core_gnt,
  output tcdm_pkg::tcdm_rsp_t [`TCDM_NB_IN-1:0] core_rsp
);

  import tcdm_pkg::*;

  // --------------------
  // memory side wiring
  // --------------------

  tcdm_req_t [`TCDM_NB_OUT-1:0] mem_req;  // winners, one per memory port.
  logic      [`TCDM_NB_OUT-1:0] mem_gnt;  // port grants back to the mux.
  tcdm_rsp_t [`TCDM_NB_OUT-1:0] mem_rsp;  // port responses, one cycle later.

  // four core channels are squeezed onto two ports by round robin.
  tcdm_mux_dynamic #(
    .NB_IN_CHAN  (`TCDM_NB_IN),
    .NB_OUT_CHAN (`TCDM_NB_OUT)
  ) mux_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),  // restarts the rotation only.
    .in_req  (core_req),
    .in_gnt  (core_gnt),
    .in_rsp  (core_rsp),
    .out_req (mem_req),
    .out_gnt (mem_gnt),
    .out_rsp (mem_rsp)
  );

  // all ports share one array. Port 0 wins on colliding bytes.
  tcdm_multiport_mem #(
    .NB_PORTS (`TCDM_NB_OUT)
  ) mem_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .port_req (mem_req),
    .port_gnt (mem_gnt),
    .port_rsp (mem_rsp)
  );

endmodule

// File: tb_tcdm_subsystem.sv
`timescale 1ns/1ps

`include "tcdm_macros.svh"

module tb_tcdm_subsystem;

  import tcdm_pkg::*;

  localparam int unsigned NB_IN      = `TCDM_NB_IN;      // core channels.
  localparam int unsigned NB_OUT     = `TCDM_NB_OUT;     // memory ports.
  localparam int unsigned G          = NB_IN / NB_OUT;   // channels that share one port.
  localparam int unsigned AW         = `TCDM_AW;
  localparam int unsigned DW         = `TCDM_DW;
  localparam int unsigned UW         = `TCDM_UW;
  localparam int unsigned BEW        = `TCDM_BEW;
  localparam int unsigned MEM_WORDS  = `TCDM_MEM_WORDS;
  localparam int unsigned CLK_PERIOD = 40;               // in ns.

  // cycle budget of each phase, summed for the watchdog.
  localparam int unsigned BUDGET_RESET = 10;
  localparam int unsigned BUDGET_T1    = 240;  // full fill plus one pass per channel.
  localparam int unsigned BUDGET_T2    = 160;
  localparam int unsigned BUDGET_T3    = 30;
  localparam int unsigned BUDGET_T4    = 210;
  localparam int unsigned BUDGET_T5    = 90;
  localparam int unsigned BUDGET_T6    = 310;
  localparam int unsigned BUDGET_TOTAL = BUDGET_RESET + BUDGET_T1 + BUDGET_T2 + BUDGET_T3
                                       + BUDGET_T4 + BUDGET_T5 + BUDGET_T6;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  tcdm_req_t [NB_IN-1:0] core_req;
  logic      [NB_IN-1:0] core_gnt;
  tcdm_rsp_t [NB_IN-1:0] core_rsp;

  logic [DW-1:0]              ref_mem [MEM_WORDS];  // reference copy of the shared memory.
  int unsigned                rr_ref;               // reference round robin offset.
  logic [NB_IN-1:0]           gnt_seen;             // grants of the last completed cycle.
  logic [NB_IN-1:0]           pend_valid;           // handshakes expecting a response.
  logic [NB_IN-1:0]           pend_read;
  logic [NB_IN-1:0][UW-1:0]   pend_user;
  logic [NB_IN-1:0][DW-1:0]   pend_data;            // word seen before this cycle's writes.
  tcdm_req_t                  wave [NB_IN];         // one request per channel, or idle.
  string                      cur_test;
  int unsigned                err_cnt;
  int unsigned                test_err_base;
  int unsigned                tests_run;
  int unsigned                tests_bad;

  tcdm_subsystem dut_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .core_req (core_req),
    .core_gnt (core_gnt),
    .core_rsp (core_rsp)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;  // 40 ns period.

  // --------------------
  // reference model
  // --------------------

  // port p scans its members from rr+p upwards, the last one that asks wins.
  function automatic logic [NB_IN-1:0] ref_grant(input logic [NB_IN-1:0] req,
                                                 input int unsigned rr);
    logic [NB_IN-1:0] g;
    int               win;
    int unsigned      m;
    g = '0;
    for (int unsigned p = 0; p < NB_OUT; p++) begin
      win = -1;  // nobody asked yet.
      for (int unsigned k = 0; k < G; k++) begin
        m = (rr + p + k) % G;
        if (req[m * NB_OUT + p]) win = int'(m);
      end
      if (win >= 0) g[win * int'(NB_OUT) + int'(p)] = 1'b1;
    end
    return g;
  endfunction

  // old word with the enabled bytes replaced.
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                                input logic [DW-1:0] new_word,
                                                input logic [BEW-1:0] be);
    logic [DW-1:0] res;
    res = old_word;
    for (int b = 0; b < int'(BEW); b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [DW-1:0] fill_word(input int unsigned addr);
    logic [7:0] a;
    a = 8'(addr);
    return {a, ~a, a ^ 8'h5a, a + 8'h3c};  // every address gives its own word.
  endfunction

  function automatic tcdm_req_t make_req(input logic wen, input logic [AW-1:0] add,
                                         input logic [BEW-1:0] be, input logic [DW-1:0] data,
                                         input logic [UW-1:0] user);
    tcdm_req_t r;
    r.req  = 1'b1;
    r.add  = add;
    r.wen  = wen;   // high means read.
    r.be   = be;
    r.data = data;
    r.user = user;
    return r;
  endfunction

  function automatic tcdm_req_t random_req(input int unsigned span);
    return make_req(1'($urandom % 2), AW'($urandom % span), BEW'($urandom), $urandom,
                    UW'($urandom));
  endfunction

  // --------------------
  // reporting
  // --------------------

  task automatic flag_mismatch(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    err_cnt++;
    $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
  endtask

  task automatic flag_problem(input string msg);
    err_cnt++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    int unsigned errs;
    repeat (2) @(posedge clk_i);  // the last responses are checked by now.
    errs = err_cnt - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %-24s ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %-24s %0d errors", cur_test, errs);
    end
  endtask

  // --------------------
  // comparing process
  // --------------------

  // sampled mid-cycle, when inputs and registered outputs have settled.
  always @(negedge clk_i) begin : compare_proc
    logic [NB_IN-1:0] req_now;
    logic [NB_IN-1:0] exp_gnt;
    int unsigned      j;
    if (!rst_ni) begin
      rr_ref     = 0;
      gnt_seen   = '0;
      pend_valid = '0;
    end else begin
      for (int unsigned c = 0; c < NB_IN; c++) begin
        if (core_rsp[c].r_valid !== pend_valid[c]) begin
          flag_mismatch($sformatf("r_valid on channel %0d", c), 32'(pend_valid[c]),
                        32'(core_rsp[c].r_valid));
        end else if (pend_valid[c]) begin
          if (core_rsp[c].r_user !== pend_user[c]) begin
            flag_mismatch($sformatf("r_user on channel %0d", c), 32'(pend_user[c]),
                          32'(core_rsp[c].r_user));
          end
          if (pend_read[c] && core_rsp[c].r_data !== pend_data[c]) begin
            flag_mismatch($sformatf("r_data on channel %0d", c), pend_data[c],
                          core_rsp[c].r_data);
          end
        end
        req_now[c] = core_req[c].req;
      end
      exp_gnt = ref_grant(req_now, rr_ref);
      if (core_gnt !== exp_gnt) begin
        flag_mismatch("grant vector", 32'(exp_gnt), 32'(core_gnt));
      end
      gnt_seen = core_gnt;  // the masters react to the real grants.
      for (int unsigned c = 0; c < NB_IN; c++) begin
        pend_valid[c] = exp_gnt[c];
        pend_read[c]  = core_req[c].wen;
        pend_user[c]  = core_req[c].user;
        pend_data[c]  = ref_mem[core_req[c].add];  // before this edge's writes.
      end
      // high port first, so port 0 lands last on shared bytes.
      for (int p = int'(NB_OUT) - 1; p >= 0; p--) begin
        for (int unsigned k = 0; k < G; k++) begin
          j = k * NB_OUT + p;
          if (pend_valid[j] && !pend_read[j]) begin
            ref_mem[core_req[j].add] = merge_bytes(ref_mem[core_req[j].add],
                                                   core_req[j].data, core_req[j].be);
          end
        end
      end
      if (clear_i) begin
        rr_ref = 0;
      end else if (|exp_gnt) begin
        rr_ref = (rr_ref + 1) % G;  // the memory grants every port that asks.
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  task automatic clear_wave();
    for (int unsigned j = 0; j < NB_IN; j++) wave[j] = '0;
  endtask

  // applies the wave and holds each request until its grant shows up.
  task automatic drive_wave();
    logic [NB_IN-1:0] left;
    int unsigned      waited;
    @(posedge clk_i);
    #2;
    for (int unsigned j = 0; j < NB_IN; j++) begin
      core_req[j] = wave[j];
      left[j]     = wave[j].req;
    end
    waited = 0;
    while (left != '0) begin
      @(posedge clk_i);
      #2;
      waited++;
      for (int unsigned j = 0; j < NB_IN; j++) begin
        if (left[j] && gnt_seen[j]) begin
          left[j]         = 1'b0;
          core_req[j].req = 1'b0;  // handshake done, channel goes idle.
        end
      end
      if (left != '0 && waited >= G) begin
        flag_problem($sformatf("channels %b got no grant within %0d cycles", left, waited));
        for (int unsigned j = 0; j < NB_IN; j++) core_req[j].req = 1'b0;
        left = '0;
      end
    end
  endtask

  // every channel asks again right after each grant, for a number of cycles.
  task automatic drive_stream(input int unsigned cycles, input int unsigned span,
                              input int clear_at);
    int unsigned wait_cnt [NB_IN];
    logic        was_clear;
    @(posedge clk_i);
    #2;
    for (int unsigned j = 0; j < NB_IN; j++) begin
      core_req[j] = random_req(span);
      wait_cnt[j] = 0;
    end
    for (int unsigned n = 1; n <= cycles + G; n++) begin
      @(posedge clk_i);
      #2;
      was_clear = clear_i;
      clear_i   = (int'(n) == clear_at);  // one cycle pulse.
      for (int unsigned j = 0; j < NB_IN; j++) begin
        if (gnt_seen[j]) begin
          wait_cnt[j] = 0;
          if (n < cycles) begin
            core_req[j] = random_req(span);
          end else begin
            core_req[j].req = 1'b0;  // stream is draining.
          end
        end else if (core_req[j].req) begin
          wait_cnt[j]++;
          if (wait_cnt[j] >= G) begin
            flag_problem($sformatf("channel %0d waited %0d cycles for a grant", j,
                                   wait_cnt[j]));
            core_req[j].req = 1'b0;
          end
        end
        if (was_clear) wait_cnt[j] = 0;  // a restart may repeat the last winner once.
      end
    end
    clear_i = 1'b0;
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin : main_proc
    logic [AW-1:0]  addr;
    logic [BEW-1:0] be_list [6];
    void'($urandom(19));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    core_req      = '0;
    err_cnt       = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_bad     = 0;
    cur_test      = "reset";
    be_list       = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'ha};
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start_test("write_read_each_channel");
    for (int unsigned a = 0; a < MEM_WORDS; a += NB_IN) begin
      for (int unsigned j = 0; j < NB_IN; j++) begin
        wave[j] = make_req(1'b0, AW'(a + j), '1, fill_word(a + j), UW'(j));
      end
      drive_wave();  // every word holds a known value from here on.
    end
    for (int unsigned j = 0; j < NB_IN; j++) begin
      addr = AW'(8'h10 + 5 * j);
      clear_wave();
      wave[j] = make_req(1'b0, addr, '1, $urandom, UW'($urandom));
      drive_wave();
      clear_wave();
      wave[j] = make_req(1'b1, addr, '0, '0, UW'($urandom));
      drive_wave();
      clear_wave();
      wave[(j + 1) % NB_IN] = make_req(1'b1, addr, '0, '0, UW'($urandom));  // other port.
      drive_wave();
    end
    end_test();

    start_test("partial_byte_writes");
    for (int unsigned j = 0; j < NB_IN; j++) begin
      for (int unsigned i = 0; i < 6; i++) begin
        addr = AW'(8'h40 + j);
        clear_wave();
        wave[j] = make_req(1'b0, addr, be_list[i], $urandom, UW'(i));
        drive_wave();
        clear_wave();
        wave[j] = make_req(1'b1, addr, '0, '0, UW'(i + 8));
        drive_wave();
      end
    end
    end_test();

    start_test("tag_and_latency");
    for (int unsigned i = 0; i < 8; i++) begin
      for (int unsigned j = 0; j < NB_IN; j++) begin
        wave[j]      = random_req(MEM_WORDS);
        wave[j].user = UW'(i * NB_IN + j);  // distinct tags in flight.
      end
      drive_wave();
    end
    end_test();

    start_test("fairness_stream");
    drive_stream(200, MEM_WORDS, -1);
    end_test();

    start_test("clear_mid_traffic");
    drive_stream(40, MEM_WORDS, 13);
    drive_stream(40, MEM_WORDS, 20);
    end_test();

    start_test("random_mixed_traffic");
    drive_stream(300, 4, -1);  // four words only, so ports often collide.
    end_test();

    $display("summary: %0d tests run, %0d clean, %0d with errors, %0d checks failing",
             tests_run, tests_run - tests_bad, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog_proc
    #(BUDGET_TOTAL * 2 * CLK_PERIOD);
    $display("watchdog: the run went past its cycle budget");
    $display("tests failed");
    $finish;
  end

endmodule

// File: tcdm_subsystem.f
+incdir+.
tcdm_pkg.sv
tcdm_mux_dynamic.sv
tcdm_multiport_mem.sv
tcdm_subsystem.sv
tb_tcdm_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the TCDM subsystem testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_tcdm_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -o "sim_$TOP" \
  -f tcdm_subsystem.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
